/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_video_out
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing -Wall
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

/* hw/flicker_blend.sv */
`timescale 1ns/1ps
`default_nettype none

module flicker_blend
	import video_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        rst,
	input  wire logic        pix_ce,
	input  wire rgb444_t     rd_pix0,
	input  wire rgb444_t     rd_pix1,
	input  wire rgb444_t     rd_pix2,
	input  wire buf_idx_t    cur_buf,
	input  wire buf_idx_t    last_buf,
	input  wire blend_mode_t blend_mode,
	input  wire logic        hblank,
	input  wire logic        vblank,
	input  wire logic        hs,
	input  wire logic        vs,
	output rgb888_t          rgb,
	output logic             de,
	output logic             hs_out,
	output logic             vs_out,
	output logic             ce_pix
);

	rgb444_t frames [NUM_BUFS];
	rgb444_t cur_pix;
	rgb444_t last_pix;
	rgb888_t mixed;

	// One colour channel, 4 bits in and 8 bits out
	function automatic logic [7:0] mix_chan(
		input blend_mode_t mode,
		input logic [3:0]  c_now,
		input logic [3:0]  c_last,
		input logic [3:0]  c0,
		input logic [3:0]  c1,
		input logic [3:0]  c2
	);
		logic [4:0]  sum2;
		logic [5:0]  sum3;
		logic [23:0] scaled;
		sum2 = {1'b0, c_now} + {1'b0, c_last};
		sum3 = {2'b00, c0} + {2'b00, c1} + {2'b00, c2};
		// Divide by three, 21845 / 16384 is close to 4/3
		scaled = {sum3, sum3[5:4]} * 24'd21845;
		case (mode)
			BLEND_TWO:   mix_chan = {sum2, sum2[4:2]};
			BLEND_THREE: mix_chan = scaled[21:14];
			default:     mix_chan = {c_now, c_now};
		endcase
	endfunction

	assign frames[0] = rd_pix0;
	assign frames[1] = rd_pix1;
	assign frames[2] = rd_pix2;
	assign cur_pix   = frames[cur_buf];
	assign last_pix  = frames[last_buf];

	assign mixed.r = mix_chan(blend_mode, cur_pix.r, last_pix.r, rd_pix0.r, rd_pix1.r, rd_pix2.r);
	assign mixed.g = mix_chan(blend_mode, cur_pix.g, last_pix.g, rd_pix0.g, rd_pix1.g, rd_pix2.g);
	assign mixed.b = mix_chan(blend_mode, cur_pix.b, last_pix.b, rd_pix0.b, rd_pix1.b, rd_pix2.b);

	always_ff @(posedge clk_sys) begin
		if (pix_ce)
			rgb <= mixed;
	end

	// Sync and blanking land with the colour of the same slot
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			de     <= 1'b0;
			hs_out <= 1'b0;
			vs_out <= 1'b0;
			ce_pix <= 1'b0;
		end else begin
			ce_pix <= pix_ce;
			if (pix_ce) begin
				de     <= ~(hblank | vblank);
				hs_out <= hs;
				vs_out <= vs;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/frame_buffers.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_buffers
	import video_pkg::*;
#(
	parameter int  FRAME_W = 224,
	parameter int  FRAME_H = 144,
	localparam int DEPTH   = FRAME_W * FRAME_H,
	localparam int ADDR_W  = $clog2(DEPTH)
) (
	input  wire logic              clk_sys,
	input  wire logic              rst,
	input  wire logic              pix_valid,
	input  wire logic [ADDR_W-1:0] pix_addr,
	input  wire rgb444_t           pix_data,
	input  wire logic              buffer_en,
	input  wire logic              sync_en,
	input  wire logic [ADDR_W-1:0] read_addr,
	input  wire logic              frame_end,
	output logic                   pix_ready,
	output rgb444_t                rd_pix0,
	output rgb444_t                rd_pix1,
	output rgb444_t                rd_pix2,
	output buf_idx_t               cur_buf,
	output buf_idx_t               last_buf
);

	buf_idx_t wr_buf;
	buf_idx_t next_buf;
	logic     sync_pause;
	logic     wr_en;
	logic     last_pix;

	assign pix_ready = ~sync_pause;
	assign wr_en     = pix_valid && pix_ready;
	assign last_pix  = wr_en && (pix_addr == ADDR_W'(DEPTH - 1));

	////////////////////
	// Frame memories
	////////////////////

	for (genvar i = 0; i < NUM_BUFS; i++) begin : g_mem
		rgb444_t mem [DEPTH];
		rgb444_t q;

		always_ff @(posedge clk_sys) begin
			if (wr_en && wr_buf == buf_idx_t'(i))
				mem[pix_addr] <= pix_data;
			q <= mem[read_addr];
		end
	end

	assign rd_pix0 = g_mem[0].q;
	assign rd_pix1 = g_mem[1].q;
	assign rd_pix2 = g_mem[2].q;

	////////////////////
	// Rotation and writer pacing
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_buf     <= '0;
			next_buf   <= '0;
			cur_buf    <= '0;
			last_buf   <= '0;
			sync_pause <= 1'b0;
		end else begin
			if (!buffer_en) begin
				wr_buf   <= '0;
				next_buf <= '0;
			end else if (last_pix) begin
				// Finished buffer becomes the next one shown
				next_buf <= wr_buf;
				wr_buf   <= (wr_buf == buf_idx_t'(NUM_BUFS - 1)) ? '0 : wr_buf + 2'd1;
			end
			if (frame_end) begin
				cur_buf  <= next_buf;
				last_buf <= cur_buf;
			end
			// Hold the core until the display has shown its frame
			if (sync_en && last_pix)
				sync_pause <= 1'b1;
			else if (frame_end)
				sync_pause <= 1'b0;
		end
	end

	a_wr_buf_range: assert property (@(posedge clk_sys) disable iff (rst)
		wr_buf != 2'd3);

endmodule

`default_nettype wire

/* hw/video_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module video_cfg
	import video_pkg::*;
(
	input  wire logic        clk_sys,
	input  wire logic        rst,
	input  wire logic        cfg_valid,
	input  wire blend_mode_t cfg_blend,
	input  wire logic        cfg_buffer_en,
	input  wire logic        cfg_sync_en,
	input  wire logic        frame_end,
	output logic             cfg_ready,
	output blend_mode_t      blend_mode,
	output logic             buffer_en,
	output logic             sync_en
);

	logic        pending;
	blend_mode_t pend_blend;
	logic        pend_buffer_en;
	logic        pend_sync_en;

	// One slot, so the writer waits for the next boundary
	assign cfg_ready = ~pending;

	always_ff @(posedge clk_sys) begin
		if (cfg_valid && cfg_ready) begin
			pend_blend     <= cfg_blend;
			pend_buffer_en <= cfg_buffer_en;
			pend_sync_en   <= cfg_sync_en;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pending    <= 1'b0;
			blend_mode <= BLEND_OFF;
			buffer_en  <= 1'b0;
			sync_en    <= 1'b0;
		end else if (cfg_valid && cfg_ready) begin
			pending <= 1'b1;
		end else if (pending && frame_end) begin
			pending    <= 1'b0;
			blend_mode <= pend_blend;
			buffer_en  <= pend_buffer_en;
			sync_en    <= pend_sync_en;
		end
	end

	// Active settings never move inside a displayed frame
	a_apply_at_boundary: assert property (@(posedge clk_sys) disable iff (rst)
		!$past(frame_end) |-> $stable({blend_mode, buffer_en, sync_en}));

endmodule

`default_nettype wire

/* hw/video_out_top.sv */
`timescale 1ns/1ps
`default_nettype none

module video_out_top
	import video_pkg::*;
#(
	parameter int  FRAME_W     = 224,
	parameter int  FRAME_H     = 144,
	parameter int  LINE_TOTAL  = 400,
	parameter int  LINES_TOTAL = 258,
	parameter int  H_START     = 31,
	parameter int  V_START     = 66,
	parameter int  PIX_DIV     = 6,
	localparam int ADDR_W      = $clog2(FRAME_W * FRAME_H)
) (
	input  wire logic              clk_sys,
	input  wire logic              rst,
	// Pixel writer
	input  wire logic              pix_valid,
	input  wire logic [ADDR_W-1:0] pix_addr,
	input  wire rgb444_t           pix_data,
	output logic                   pix_ready,
	// Configuration
	input  wire logic              cfg_valid,
	input  wire blend_mode_t       cfg_blend,
	input  wire logic              cfg_buffer_en,
	input  wire logic              cfg_sync_en,
	output logic                   cfg_ready,
	// Display
	output rgb888_t                rgb,
	output logic                   de,
	output logic                   hs,
	output logic                   vs,
	output logic                   ce_pix
);

	blend_mode_t       blend_mode;
	logic              buffer_en;
	logic              sync_en;
	logic              pix_ce;
	logic              frame_end;
	logic [ADDR_W-1:0] read_addr;
	logic              tim_hblank;
	logic              tim_vblank;
	logic              tim_hs;
	logic              tim_vs;
	rgb444_t           rd_pix0;
	rgb444_t           rd_pix1;
	rgb444_t           rd_pix2;
	buf_idx_t          cur_buf;
	buf_idx_t          last_buf;

	video_cfg u_cfg (
		.clk_sys(clk_sys), .rst(rst), .cfg_valid(cfg_valid), .cfg_blend(cfg_blend),
		.cfg_buffer_en(cfg_buffer_en), .cfg_sync_en(cfg_sync_en), .frame_end(frame_end),
		.cfg_ready(cfg_ready), .blend_mode(blend_mode), .buffer_en(buffer_en),
		.sync_en(sync_en)
	);

	frame_buffers #(.FRAME_W(FRAME_W), .FRAME_H(FRAME_H)) u_bufs (
		.clk_sys(clk_sys), .rst(rst), .pix_valid(pix_valid), .pix_addr(pix_addr),
		.pix_data(pix_data), .buffer_en(buffer_en), .sync_en(sync_en),
		.read_addr(read_addr), .frame_end(frame_end), .pix_ready(pix_ready),
		.rd_pix0(rd_pix0), .rd_pix1(rd_pix1), .rd_pix2(rd_pix2),
		.cur_buf(cur_buf), .last_buf(last_buf)
	);

	video_timing #(
		.FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .LINE_TOTAL(LINE_TOTAL),
		.LINES_TOTAL(LINES_TOTAL), .H_START(H_START), .V_START(V_START), .PIX_DIV(PIX_DIV)
	) u_timing (
		.clk_sys(clk_sys), .rst(rst), .pix_ce(pix_ce), .read_addr(read_addr),
		.hblank(tim_hblank), .vblank(tim_vblank), .hs(tim_hs), .vs(tim_vs),
		.frame_end(frame_end)
	);

	flicker_blend u_blend (
		.clk_sys(clk_sys), .rst(rst), .pix_ce(pix_ce), .rd_pix0(rd_pix0),
		.rd_pix1(rd_pix1), .rd_pix2(rd_pix2), .cur_buf(cur_buf), .last_buf(last_buf),
		.blend_mode(blend_mode), .hblank(tim_hblank), .vblank(tim_vblank),
		.hs(tim_hs), .vs(tim_vs), .rgb(rgb), .de(de), .hs_out(hs), .vs_out(vs),
		.ce_pix(ce_pix)
	);

endmodule

`default_nettype wire

/* hw/video_pkg.sv */
`default_nettype none

package video_pkg;

	// Stored pixel as written by the core
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb444_t;

	// Displayed pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb888_t;

	typedef enum logic [1:0] {
		BLEND_OFF   = 2'd0,
		BLEND_TWO   = 2'd1,
		BLEND_THREE = 2'd2
	} blend_mode_t;

	typedef logic [1:0] buf_idx_t;

	localparam int NUM_BUFS = 3;

endpackage

`default_nettype wire

/* hw/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
	parameter int  FRAME_W     = 224,
	parameter int  FRAME_H     = 144,
	parameter int  LINE_TOTAL  = 400,
	parameter int  LINES_TOTAL = 258,
	parameter int  H_START     = 31,
	parameter int  V_START     = 66,
	parameter int  PIX_DIV     = 6,
	localparam int ADDR_W      = $clog2(FRAME_W * FRAME_H)
) (
	input  wire logic        clk_sys,
	input  wire logic        rst,
	output logic             pix_ce,
	output logic [ADDR_W-1:0] read_addr,
	output logic             hblank,
	output logic             vblank,
	output logic             hs,
	output logic             vs,
	output logic             frame_end
);

	localparam int X_W    = $clog2(LINE_TOTAL);
	localparam int Y_W    = $clog2(LINES_TOTAL);
	localparam int DIV_W  = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
	// Short lines get a shorter pulse
	localparam int HS_LEN = (LINE_TOTAL > 64) ? 32 : LINE_TOTAL / 4;

	logic [DIV_W-1:0] div;
	logic [X_W-1:0]   x;
	logic [Y_W-1:0]   y;
	logic             h_act;
	logic             v_act;
	logic             line_end;
	logic             last_line;

	assign h_act     = (x >= X_W'(H_START)) && (x < X_W'(H_START + FRAME_W));
	assign v_act     = (y >= Y_W'(V_START)) && (y < Y_W'(V_START + FRAME_H));
	assign line_end  = x == X_W'(LINE_TOTAL - 1);
	assign last_line = y == Y_W'(LINES_TOTAL - 1);

	////////////////////
	// Pixel clock enable
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div    <= '0;
			pix_ce <= 1'b0;
		end else begin
			pix_ce <= div == DIV_W'(PIX_DIV - 1);
			div    <= (div == DIV_W'(PIX_DIV - 1)) ? '0 : div + 1'b1;
		end
	end

	////////////////////
	// Position, sync and read address
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			x         <= '0;
			y         <= '0;
			hblank    <= 1'b1;
			vblank    <= 1'b1;
			hs        <= 1'b0;
			vs        <= 1'b0;
			read_addr <= '0;
			frame_end <= 1'b0;
		end else begin
			frame_end <= 1'b0;
			if (pix_ce) begin
				hblank <= ~h_act;
				vblank <= ~v_act;
				hs     <= x >= X_W'(LINE_TOTAL - HS_LEN);
				vs     <= (y >= Y_W'(1)) && (y <= Y_W'(3));

				// Address runs one slot ahead of the output register
				if (vblank)
					read_addr <= '0;
				else if (!hblank)
					read_addr <= read_addr + 1'b1;

				if (line_end) begin
					x <= '0;
					if (last_line) begin
						y         <= '0;
						frame_end <= 1'b1;
					end else begin
						y <= y + 1'b1;
					end
				end else begin
					x <= x + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tb_video_out.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_video_out
	import video_pkg::*;
();

	localparam int FRAME_W     = 8;
	localparam int FRAME_H     = 4;
	localparam int LINE_TOTAL  = 16;
	localparam int LINES_TOTAL = 8;
	localparam int H_START     = 2;
	localparam int V_START     = 2;
	localparam int PIX_DIV     = 2;
	localparam int FRAME_PIX   = FRAME_W * FRAME_H;
	localparam int ADDR_W      = $clog2(FRAME_PIX);
	// Three whole display frames
	localparam int WAIT_LIMIT  = 3 * LINE_TOTAL * LINES_TOTAL * PIX_DIV;

	logic              clk_sys = 1'b0;
	logic              rst;
	logic              pix_valid;
	logic [ADDR_W-1:0] pix_addr;
	rgb444_t           pix_data;
	logic              pix_ready;
	logic              cfg_valid;
	blend_mode_t       cfg_blend;
	logic              cfg_buffer_en;
	logic              cfg_sync_en;
	logic              cfg_ready;
	rgb888_t           rgb;
	logic              de;
	logic              hs;
	logic              vs;
	logic              ce_pix;

	int          errors = 0;
	int          errors_before = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	logic        sync_mode = 1'b0;
	logic        timed_out = 1'b0;
	logic [31:0] rng = 32'd16;
	rgb444_t     frame_mem [FRAME_PIX];
	rgb888_t     shown [FRAME_PIX];
	rgb444_t     col_a;
	rgb444_t     col_b;
	rgb444_t     col_c;

	always #4 clk_sys = ~clk_sys;

	video_out_top #(
		.FRAME_W(FRAME_W), .FRAME_H(FRAME_H), .LINE_TOTAL(LINE_TOTAL),
		.LINES_TOTAL(LINES_TOTAL), .H_START(H_START), .V_START(V_START), .PIX_DIV(PIX_DIV)
	) dut0 (
		.clk_sys(clk_sys), .rst(rst), .pix_valid(pix_valid), .pix_addr(pix_addr),
		.pix_data(pix_data), .pix_ready(pix_ready), .cfg_valid(cfg_valid),
		.cfg_blend(cfg_blend), .cfg_buffer_en(cfg_buffer_en), .cfg_sync_en(cfg_sync_en),
		.cfg_ready(cfg_ready), .rgb(rgb), .de(de), .hs(hs), .vs(vs), .ce_pix(ce_pix)
	);

	////////////////////
	// Handshake rules
	////////////////////

	a_cfg_slot_fills: assert property (@(posedge clk_sys) disable iff (rst)
		cfg_valid && cfg_ready |=> !cfg_ready)
	else begin
		$display("cfg_ready stayed high after a configuration transfer");
		errors = errors + 1;
	end

	a_pause_after_last: assert property (@(posedge clk_sys) disable iff (rst)
		sync_mode && pix_valid && pix_ready && pix_addr == ADDR_W'(FRAME_PIX - 1)
		|=> !pix_ready)
	else begin
		$display("pix_ready stayed high after the last pixel of a frame");
		errors = errors + 1;
	end

	////////////////////
	// Expected colours
	////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic rgb444_t random_colour();
		rng = xorshift(rng);
		return rgb444_t'(rng[11:0]);
	endfunction

	// n * 17 repeats the nibble
	function automatic logic [7:0] rule_off(input logic [3:0] n);
		return 8'(n * 17);
	endfunction

	function automatic logic [7:0] rule_two(input logic [3:0] n0, input logic [3:0] n1);
		int s;
		s = n0 + n1;
		return 8'(s * 8 + s / 4);
	endfunction

	function automatic logic [7:0] rule_three(input logic [3:0] n0, input logic [3:0] n1,
			input logic [3:0] n2);
		int s;
		int w;
		s = n0 + n1 + n2;
		w = s * 4 + s / 16;
		return 8'((w * 21845) / 16384);
	endfunction

	function automatic rgb888_t expect_off(input rgb444_t p);
		rgb888_t e;
		e.r = rule_off(p.r);
		e.g = rule_off(p.g);
		e.b = rule_off(p.b);
		return e;
	endfunction

	function automatic rgb888_t expect_two(input rgb444_t now, input rgb444_t prev);
		rgb888_t e;
		e.r = rule_two(now.r, prev.r);
		e.g = rule_two(now.g, prev.g);
		e.b = rule_two(now.b, prev.b);
		return e;
	endfunction

	function automatic rgb888_t expect_three(input rgb444_t p0, input rgb444_t p1,
			input rgb444_t p2);
		rgb888_t e;
		e.r = rule_three(p0.r, p1.r, p2.r);
		e.g = rule_three(p0.g, p1.g, p2.g);
		e.b = rule_three(p0.b, p1.b, p2.b);
		return e;
	endfunction

	////////////////////
	// Checks and waits
	////////////////////

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp)
		else begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			errors = errors + 1;
		end
	endtask

	task automatic check_pixel(input string name, input int k, input rgb888_t exp,
			input rgb888_t act);
		assert (act === exp)
		else begin
			$display("mismatch %s pixel %0d expected %h actual %h", name, k, exp, act);
			errors = errors + 1;
		end
	endtask

	task automatic check_frame(input string name, input rgb888_t exp);
		for (int k = 0; k < FRAME_PIX; k++)
			check_pixel(name, k, exp, shown[k]);
	endtask

	// Whole captured frame holds one colour
	function automatic bit frame_matches(input rgb888_t exp);
		bit same;
		same = 1'b1;
		for (int k = 0; k < FRAME_PIX; k++)
			if (shown[k] !== exp)
				same = 1'b0;
		return same;
	endfunction

	task automatic note_timeout(input string what);
		$display("timeout: %s", what);
		timed_out = 1'b1;
		errors    = errors + 1;
	endtask

	task automatic wait_pix_ready(input string what);
		int n;
		if (timed_out)
			return;
		n = 0;
		while (!pix_ready && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!pix_ready)
			note_timeout(what);
	endtask

	task automatic wait_cfg_ready(input string what);
		int n;
		if (timed_out)
			return;
		n = 0;
		while (!cfg_ready && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!cfg_ready)
			note_timeout(what);
	endtask

	task automatic write_pixel(input logic [ADDR_W-1:0] addr, input rgb444_t data);
		pix_valid = 1'b1;
		pix_addr  = addr;
		pix_data  = data;
		wait_pix_ready("pix_ready stayed low while writing a pixel");
		// Transfer lands on the rising edge in between
		@(negedge clk_sys);
	endtask

	task automatic write_frame(input logic random_fill, input rgb444_t fill);
		rgb444_t data;
		for (int k = 0; k < FRAME_PIX; k++) begin
			data = random_fill ? random_colour() : fill;
			frame_mem[k] = data;
			write_pixel(ADDR_W'(k), data);
		end
		pix_valid = 1'b0;
	endtask

	task automatic send_cfg(input blend_mode_t mode, input logic buf_en, input logic sync);
		cfg_valid     = 1'b1;
		cfg_blend     = mode;
		cfg_buffer_en = buf_en;
		cfg_sync_en   = sync;
		wait_cfg_ready("cfg_ready stayed low before a configuration transfer");
		@(negedge clk_sys);
		cfg_valid = 1'b0;
	endtask

	// Rising vs seen on the pixel enable
	task automatic wait_frame_start();
		int   n;
		logic prev_vs;
		logic seen;
		if (timed_out)
			return;
		n       = 0;
		prev_vs = 1'b1;
		seen    = 1'b0;
		while (!seen && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
			if (ce_pix) begin
				seen    = vs && !prev_vs;
				prev_vs = vs;
			end
		end
		if (!seen)
			note_timeout("no vertical sync seen");
	endtask

	task automatic collect_frame();
		int n;
		int k;
		if (timed_out)
			return;
		n = 0;
		k = 0;
		while (k < FRAME_PIX && n < WAIT_LIMIT) begin
			@(negedge clk_sys);
			n++;
			if (ce_pix && de) begin
				shown[k] = rgb;
				k++;
			end
		end
		if (k < FRAME_PIX)
			note_timeout("too few active pixels in a displayed frame");
	endtask

	task automatic capture_frame();
		wait_frame_start();
		collect_frame();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors != errors_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end else begin
			$display("test %s: ok", name);
		end
		errors_before = errors;
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		rst           = 1'b1;
		pix_valid     = 1'b0;
		pix_addr      = '0;
		pix_data      = '0;
		cfg_valid     = 1'b0;
		cfg_blend     = BLEND_OFF;
		cfg_buffer_en = 1'b0;
		cfg_sync_en   = 1'b0;
		repeat (4) @(negedge clk_sys);
		rst = 1'b0;

		// Outputs before the first pixel enable
		@(negedge clk_sys);
		check_bit("reset ce_pix", 1'b0, ce_pix);
		check_bit("reset de", 1'b0, de);
		check_bit("reset hs", 1'b0, hs);
		check_bit("reset vs", 1'b0, vs);
		check_bit("reset pix_ready", 1'b1, pix_ready);
		check_bit("reset cfg_ready", 1'b1, cfg_ready);
		finish_test("reset");

		// Single buffer, plain expansion
		write_frame(1'b1, '0);
		capture_frame();
		for (int k = 0; k < FRAME_PIX; k++)
			check_pixel("blend off", k, expect_off(frame_mem[k]), shown[k]);
		finish_test("blend off");

		col_a = random_colour();
		col_b = random_colour();
		col_c = random_colour();
		send_cfg(BLEND_OFF, 1'b1, 1'b0);
		wait_cfg_ready("buffering was never switched on");
		write_frame(1'b0, col_a);
		write_frame(1'b0, col_b);
		write_frame(1'b0, col_c);
		capture_frame();
		// Settling frame may still show an older finished buffer
		if (!frame_matches(expect_off(col_a)) && !frame_matches(expect_off(col_b)))
			check_frame("rotation settling", expect_off(col_c));
		capture_frame();
		check_frame("rotation", expect_off(col_c));
		finish_test("rotation");

		send_cfg(BLEND_TWO, 1'b1, 1'b0);
		wait_cfg_ready("blend two was never applied");
		capture_frame();
		check_frame("blend two", expect_two(col_c, col_c));
		send_cfg(BLEND_THREE, 1'b1, 1'b0);
		wait_cfg_ready("blend three was never applied");
		capture_frame();
		check_frame("blend three", expect_three(col_a, col_b, col_c));
		finish_test("blending");

		// New mode requested inside a frame
		wait_frame_start();
		send_cfg(BLEND_OFF, 1'b1, 1'b0);
		check_bit("cfg_ready after transfer", 1'b0, cfg_ready);
		collect_frame();
		check_frame("cfg mid frame", expect_three(col_a, col_b, col_c));
		check_bit("cfg_ready inside frame", 1'b0, cfg_ready);
		wait_cfg_ready("pending settings were never applied");
		capture_frame();
		check_frame("cfg next frame", expect_off(col_c));
		finish_test("cfg handshake");

		send_cfg(BLEND_OFF, 1'b0, 1'b1);
		wait_cfg_ready("sync pause was never applied");
		sync_mode = 1'b1;
		write_frame(1'b1, '0);
		// A leaked write would show at address 0
		pix_valid = 1'b1;
		pix_addr  = '0;
		pix_data  = rgb444_t'(~frame_mem[0]);
		check_bit("pix_ready after last pixel", 1'b0, pix_ready);
		wait_pix_ready("pix_ready did not rise after the frame boundary");
		pix_valid = 1'b0;
		capture_frame();
		for (int k = 0; k < FRAME_PIX; k++)
			check_pixel("sync pause", k, expect_off(frame_mem[k]), shown[k]);
		finish_test("sync pause");

		$display("tests run %0d, failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/video_pkg.sv
hw/video_cfg.sv
hw/frame_buffers.sv
hw/video_timing.sv
hw/flicker_blend.sv
hw/video_out_top.sv
sim/tb_video_out.sv
